// ==== hw/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data word width
`define XLEN 32

// byte address width of the program counter and memory ports
`define ADDR_WIDTH 10

// architectural integer registers
`define REG_COUNT 32

`endif

// ==== hw/isa_pkg.sv ====
package isa_pkg;

  // register index field
  typedef logic [4:0] reg_idx_t;

  // instruction fields
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // major opcodes of the kept subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_t;

  // alu funct3, shared by OP and OP_IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // word access only
  localparam funct3_t F3_LW = 3'b010;
  localparam funct3_t F3_SW = 3'b010;

  // branch conditions
  localparam funct3_t F3_BEQ = 3'b000;
  localparam funct3_t F3_BNE = 3'b001;

  // funct7 marking SUB and SRA / SRAI
  localparam funct7_t F7_ALT = 7'b0100000;

endpackage

// ==== hw/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

  // datapath word and memory / pc address
  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // alu operations
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  // first operand source, zero is for LUI
  typedef enum logic [1:0] {
    A_RS1  = 2'd0,
    A_PC   = 2'd1,
    A_ZERO = 2'd2
  } a_sel_t;

  // second operand source
  typedef enum logic {
    B_RS2 = 1'b0,
    B_IMM = 1'b1
  } b_sel_t;

  // writeback source
  typedef enum logic {
    WB_ALU = 1'b0,
    WB_MEM = 1'b1
  } wb_sel_t;

endpackage

// ==== hw/ctrl_if.sv ====
`timescale 1ns/10ps

interface ctrl_if;
  import core_pkg::*;

  // decoded control for one instruction
  alu_op_t alu_op;
  a_sel_t  a_sel;
  b_sel_t  b_sel;
  wb_sel_t wb_sel;
  logic    reg_write;
  logic    mem_write;
  logic    branch;
  logic    branch_ne;

  modport decoder (
    output alu_op, a_sel, b_sel, wb_sel, reg_write, mem_write, branch, branch_ne
  );

  // datapath side, no enables needed here
  modport execute (input alu_op, a_sel, b_sel, wb_sel, branch, branch_ne);

  modport regs (input reg_write);

endinterface

// ==== hw/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder (
  input  core_pkg::word_t instr,
  ctrl_if.decoder         ctrl
);
  import core_pkg::*;
  import isa_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // alu op from funct3
  // alt picks SUB over ADD, SRA over SRL
  function automatic alu_op_t alu_from_f3(input funct3_t f3, input logic alt);
    case (f3)
      F3_ADD_SUB: alu_from_f3 = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_from_f3 = ALU_SLL;
      F3_SLT:     alu_from_f3 = ALU_SLT;
      F3_SLTU:    alu_from_f3 = ALU_SLTU;
      F3_XOR:     alu_from_f3 = ALU_XOR;
      F3_SRL_SRA: alu_from_f3 = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_from_f3 = ALU_OR;
      default:    alu_from_f3 = ALU_AND;
    endcase
  endfunction

  always_comb begin
    // nop defaults, also used for unknown opcodes
    ctrl.alu_op    = ALU_ADD;
    ctrl.a_sel     = A_RS1;
    ctrl.b_sel     = B_RS2;
    ctrl.wb_sel    = WB_ALU;
    ctrl.reg_write = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.branch    = 1'b0;
    ctrl.branch_ne = 1'b0;
    case (opcode)
      OPC_OP: begin
        ctrl.alu_op    = alu_from_f3(funct3, funct7 == F7_ALT);
        ctrl.reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        // no SUBI, funct7 only matters for right shifts
        ctrl.alu_op    = alu_from_f3(funct3, (funct3 == F3_SRL_SRA) && (funct7 == F7_ALT));
        ctrl.b_sel     = B_IMM;
        ctrl.reg_write = 1'b1;
      end
      OPC_LOAD: begin
        // address is rs1 + imm
        ctrl.b_sel     = B_IMM;
        ctrl.wb_sel    = WB_MEM;
        ctrl.reg_write = (funct3 == F3_LW);
      end
      OPC_STORE: begin
        ctrl.b_sel     = B_IMM;
        ctrl.mem_write = (funct3 == F3_SW);
      end
      OPC_BRANCH: begin
        // compare by subtraction, zero flag in execute
        ctrl.alu_op    = ALU_SUB;
        ctrl.branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        ctrl.branch_ne = (funct3 == F3_BNE);
      end
      OPC_LUI: begin
        ctrl.a_sel     = A_ZERO;
        ctrl.b_sel     = B_IMM;
        ctrl.reg_write = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl.a_sel     = A_PC;
        ctrl.b_sel     = B_IMM;
        ctrl.reg_write = 1'b1;
      end
      default: begin
      end
    endcase
    // a store never writes the register file
    assert (!(ctrl.mem_write && ctrl.reg_write))
      else $error("decoder: store with register write");
  end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps

`include "core_config.svh"

module reg_file (
  input  logic              CLK,
  input  logic              RESET_N,
  input  isa_pkg::reg_idx_t rs1,
  input  isa_pkg::reg_idx_t rs2,
  input  isa_pkg::reg_idx_t rd,
  input  core_pkg::word_t   wb_data,
  ctrl_if.regs              ctrl,
  output core_pkg::word_t   rs1_data,
  output core_pkg::word_t   rs2_data
);
  import core_pkg::*;

  word_t regs [`REG_COUNT];

  // x0 never written, so it keeps its reset value
  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_write && (rd != '0)) begin
      regs[rd] <= wb_data;
    end
  end

  // combinational read ports
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 reads zero on both ports, whatever was written before
  x0_reads_zero: assert property (
    @(posedge CLK) disable iff (!RESET_N)
      ((rs1 != '0) || (rs1_data == '0)) && ((rs2 != '0) || (rs2_data == '0))
  ) else $error("reg_file: x0 read returned nonzero");

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/10ps

`include "core_config.svh"

module imm_gen (
  input  core_pkg::word_t instr,
  output core_pkg::word_t imm
);
  import core_pkg::*;
  import isa_pkg::*;

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;

  // I format, ALU immediates and loads
  assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};

  // S format, offset split around rd field
  assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

  // B format, scattered offset in half words
  assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};

  // U format, upper 20 bits
  assign imm_u = {instr[31:12], 12'b0};

  always_comb begin
    case (opcode_t'(instr[6:0]))
      OPC_OP_IMM, OPC_LOAD: imm = imm_i;
      OPC_STORE:            imm = imm_s;
      OPC_BRANCH:           imm = imm_b;
      OPC_LUI, OPC_AUIPC:   imm = imm_u;
      // R type and unknown
      default:              imm = '0;
    endcase
  end

endmodule

// ==== hw/execute.sv ====
`timescale 1ns/10ps

`include "core_config.svh"

module execute (
  ctrl_if.execute         ctrl,
  input  core_pkg::addr_t pc,
  input  core_pkg::word_t rs1_data,
  input  core_pkg::word_t rs2_data,
  input  core_pkg::word_t imm,
  input  core_pkg::word_t load_data,
  output core_pkg::word_t alu_result,
  output core_pkg::addr_t mem_word_addr,
  output core_pkg::word_t wb_data,
  output logic            branch_taken
);
  import core_pkg::*;

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       zero;

  // first operand, pc zero-extended for AUIPC
  always_comb begin
    case (ctrl.a_sel)
      A_PC:    op_a = {{(`XLEN-`ADDR_WIDTH){1'b0}}, pc};
      A_ZERO:  op_a = '0;
      default: op_a = rs1_data;
    endcase
  end

  assign op_b  = (ctrl.b_sel == B_IMM) ? imm : rs2_data;
  // only low 5 bits shift
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_result = op_a + op_b;
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_SLL:  alu_result = op_a << shamt;
      ALU_SLT:  alu_result = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU: alu_result = word_t'(op_a < op_b);
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SRL:  alu_result = op_a >> shamt;
      ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
      ALU_OR:   alu_result = op_a | op_b;
      ALU_AND:  alu_result = op_a & op_b;
      default:  alu_result = '0;
    endcase
  end

  // branches use SUB, zero means equal
  assign zero         = (alu_result == '0);
  assign branch_taken = ctrl.branch && (ctrl.branch_ne ? !zero : zero);

  // word index of the byte address
  assign mem_word_addr = alu_result[`ADDR_WIDTH+1:2];

  assign wb_data = (ctrl.wb_sel == WB_MEM) ? load_data : alu_result;

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/10ps

`include "core_config.svh"

module fetch_unit (
  input  logic            CLK,
  input  logic            RESET_N,
  input  core_pkg::word_t imm,
  input  logic            branch_taken,
  output core_pkg::addr_t pc,
  output core_pkg::addr_t iaddr
);
  import core_pkg::*;

  addr_t pc_q;
  addr_t pc_seq;
  addr_t pc_target;

  // sequential and branch targets, wrap at ADDR_WIDTH
  assign pc_seq    = pc_q + addr_t'(4);
  assign pc_target = pc_q + imm[`ADDR_WIDTH-1:0];

  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      pc_q <= '0;
    end else begin
      pc_q <= branch_taken ? pc_target : pc_seq;
    end
  end

  assign pc    = pc_q;
  // instruction memory is word indexed
  assign iaddr = {2'b00, pc_q[`ADDR_WIDTH-1:2]};

  // misaligned branch offset would break word fetch
  pc_aligned: assert property (
    @(posedge CLK) disable iff (!RESET_N) pc_q[1:0] == 2'b00
  ) else $error("fetch_unit: pc not word aligned");

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/10ps

module rv_core (
  input  logic            CLK,
  input  logic            RESET_N,
  input  core_pkg::word_t idata,
  output core_pkg::addr_t iaddr,
  output core_pkg::addr_t daddr,
  input  core_pkg::word_t ddata_r,
  output core_pkg::word_t ddata_w,
  output logic            d_rw
);
  import core_pkg::*;

  isa_pkg::reg_idx_t rs1_idx;
  isa_pkg::reg_idx_t rs2_idx;
  isa_pkg::reg_idx_t rd_idx;

  word_t rs1_data;
  word_t rs2_data;
  word_t imm;
  word_t wb_data;
  addr_t pc;
  logic  branch_taken;

  // register fields of the instruction
  assign rs1_idx = idata[19:15];
  assign rs2_idx = idata[24:20];
  assign rd_idx  = idata[11:7];

  ctrl_if ctrl_bus ();

  instr_decoder u_decoder (
    .instr (idata),
    .ctrl  (ctrl_bus.decoder)
  );

  reg_file u_regs (
    .CLK      (CLK),
    .RESET_N  (RESET_N),
    .rs1      (rs1_idx),
    .rs2      (rs2_idx),
    .rd       (rd_idx),
    .wb_data  (wb_data),
    .ctrl     (ctrl_bus.regs),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  imm_gen u_imm (
    .instr (idata),
    .imm   (imm)
  );

  // daddr taken straight from the word address output
  execute u_exec (
    .ctrl          (ctrl_bus.execute),
    .pc            (pc),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .imm           (imm),
    .load_data     (ddata_r),
    .alu_result    (),
    .mem_word_addr (daddr),
    .wb_data       (wb_data),
    .branch_taken  (branch_taken)
  );

  fetch_unit u_fetch (
    .CLK          (CLK),
    .RESET_N      (RESET_N),
    .imm          (imm),
    .branch_taken (branch_taken),
    .pc           (pc),
    .iaddr        (iaddr)
  );

  // store data is rs2, write strobe from decoder
  assign ddata_w = rs2_data;
  assign d_rw    = ctrl_bus.mem_write;

endmodule

// ==== dv/clk_gen.sv ====
`timescale 1ns/10ps

module clk_gen (
  output logic CLK,
  output logic RESET_N
);

  // 40 ns period
  initial begin
    CLK = 1'b0;
    forever begin
      #20 CLK = ~CLK;
    end
  end

  // reset held low for 8 cycles, released just after an edge
  initial begin
    RESET_N = 1'b0;
    repeat (8) @(posedge CLK);
    #1 RESET_N = 1'b1;
  end

endmodule

// ==== dv/tb_core.sv ====
`timescale 1ns/10ps

module tb_core;
  import core_pkg::*;

  localparam int MAX_ENTRIES = 64;
  localparam word_t NOP = 32'h00000013;

  logic  CLK;
  logic  RESET_N;
  word_t idata;
  addr_t iaddr;
  addr_t daddr;
  word_t ddata_r;
  word_t ddata_w;
  logic  d_rw;

  // program table
  word_t t_instr [MAX_ENTRIES];
  addr_t t_iaddr [MAX_ENTRIES];
  logic  t_store [MAX_ENTRIES];
  addr_t t_daddr [MAX_ENTRIES];
  word_t t_wdata [MAX_ENTRIES];
  int    n_entries;
  addr_t next_word;
  int    slot;

  logic [31:0] lfsr_state;
  word_t       dmem [16];

  clk_gen u_clk (.CLK(CLK), .RESET_N(RESET_N));

  rv_core u_dut (
    .CLK     (CLK),
    .RESET_N (RESET_N),
    .idata   (idata),
    .iaddr   (iaddr),
    .daddr   (daddr),
    .ddata_r (ddata_r),
    .ddata_w (ddata_w),
    .d_rw    (d_rw)
  );

  // 16 word data memory, combinational read
  assign ddata_r = dmem[daddr[3:0]];
  always @(posedge CLK) begin
    if (d_rw) begin
      dmem[daddr[3:0]] <= ddata_w;
    end
  end

  // galois lfsr, taps for x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one step per bit taken
  task automatic rand_bits(input int n, output word_t r);
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
  endtask

  // instruction encoders
  function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd);
    enc_r = {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] op);
    enc_i = {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1);
    enc_s = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
    enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  // entry that stores nothing, iaddr follows the program order
  task automatic add_plain(input word_t instr);
    t_instr[n_entries] = instr;
    t_iaddr[n_entries] = next_word;
    t_store[n_entries] = 1'b0;
    t_daddr[n_entries] = '0;
    t_wdata[n_entries] = '0;
    n_entries++;
    next_word = next_word + addr_t'(1);
  endtask

  // SW rs2 into the next slot, base x5 holds 4
  task automatic add_store(input logic [4:0] rs2, input word_t exp_data);
    t_instr[n_entries] = enc_s(12'(slot * 4), rs2, 5'd5);
    t_iaddr[n_entries] = next_word;
    t_store[n_entries] = 1'b1;
    t_daddr[n_entries] = addr_t'(slot + 1);
    t_wdata[n_entries] = exp_data;
    n_entries++;
    slot++;
    next_word = next_word + addr_t'(1);
  endtask

  // branch offset in bytes, target word index when taken
  task automatic add_branch(input word_t instr, input logic taken, input int offset);
    addr_t here;
    here = next_word;
    add_plain(instr);
    if (taken) begin
      next_word = here + addr_t'(offset / 4);
    end
  endtask

  // LI pattern, ADDI sign-extends so upper part compensates
  task automatic load_reg(input logic [4:0] rd, input word_t val);
    word_t lo;
    word_t hi;
    lo = {{20{val[11]}}, val[11:0]};
    hi = val - lo;
    add_plain({hi[31:12], rd, 7'b0110111});
    add_plain(enc_i(val[11:0], rd, 3'b000, rd, 7'b0010011));
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("ERR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("ERR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  task automatic build_program();
    word_t a;
    word_t b;
    word_t c;
    word_t ximm;
    word_t sh;
    addr_t pc_word;
    n_entries = 0;
    next_word = '0;
    slot = 0;
    rand_bits(32, a);
    rand_bits(32, b);
    rand_bits(20, c);
    rand_bits(12, ximm);
    rand_bits(5, sh);
    ximm = {{20{ximm[11]}}, ximm[11:0]};
    // base register and operands
    add_plain(enc_i(12'd4, 5'd0, 3'b000, 5'd5, 7'b0010011));
    load_reg(5'd1, a);
    load_reg(5'd2, b);
    // register-register ops, results stored in turn
    add_plain(enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3));
    add_store(5'd3, a + b);
    add_plain(enc_r(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3));
    add_store(5'd3, a - b);
    add_plain(enc_r(7'b0000000, 5'd2, 5'd1, 3'b010, 5'd3));
    add_store(5'd3, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    add_plain(enc_r(7'b0000000, 5'd2, 5'd1, 3'b011, 5'd3));
    add_store(5'd3, (a < b) ? 32'd1 : 32'd0);
    add_plain(enc_r(7'b0100000, 5'd2, 5'd1, 3'b101, 5'd3));
    add_store(5'd3, word_t'($signed(a) >>> b[4:0]));
    add_plain(enc_r(7'b0000000, 5'd2, 5'd1, 3'b101, 5'd3));
    add_store(5'd3, a >> b[4:0]);
    // immediate ops
    add_plain(enc_i(ximm[11:0], 5'd1, 3'b100, 5'd3, 7'b0010011));
    add_store(5'd3, a ^ ximm);
    add_plain(enc_i({7'b0000000, sh[4:0]}, 5'd1, 3'b001, 5'd3, 7'b0010011));
    add_store(5'd3, a << sh[4:0]);
    add_plain(enc_i({7'b0100000, sh[4:0]}, 5'd1, 3'b101, 5'd3, 7'b0010011));
    add_store(5'd3, word_t'($signed(a) >>> sh[4:0]));
    // known less-than cases, x4 = -1
    add_plain(enc_i(12'hfff, 5'd0, 3'b000, 5'd4, 7'b0010011));
    add_plain(enc_r(7'b0000000, 5'd4, 5'd0, 3'b011, 5'd3));
    add_store(5'd3, 32'd1);
    add_plain(enc_r(7'b0000000, 5'd0, 5'd4, 3'b010, 5'd3));
    add_store(5'd3, 32'd1);
    // load back the ADD result from word 1
    add_plain(enc_i(12'd0, 5'd5, 3'b010, 5'd6, 7'b0000011));
    add_store(5'd6, a + b);
    // auipc adds its own pc
    pc_word = next_word;
    add_plain({c[19:0], 5'd7, 7'b0010111});
    add_store(5'd7, word_t'({pc_word, 2'b00}) + {c[19:0], 12'b0});
    // branches, taken and not taken
    add_branch(enc_b(13'd8, 5'd1, 5'd1, 3'b000), 1'b1, 8);
    add_branch(enc_b(13'd12, 5'd2, 5'd1, 3'b000), a == b, 12);
    add_branch(enc_b(13'd16, 5'd2, 5'd1, 3'b001), a != b, 16);
    add_branch(enc_b(13'd8, 5'd1, 5'd1, 3'b001), 1'b0, 8);
    // x0 stays zero after a write
    add_plain(enc_i(12'd123, 5'd0, 3'b000, 5'd0, 7'b0010011));
    add_store(5'd0, 32'd0);
  endtask

  initial begin
    int cycles;
    idata = NOP;
    lfsr_state = 32'd1257;
    for (int i = 0; i < 16; i++) begin
      dmem[i] = 32'hc0de0000 ^ (i * 32'h00010111);
    end
    build_program();

    // wait for reset release
    cycles = 0;
    while (RESET_N !== 1'b1) begin
      @(posedge CLK);
      #2;
      cycles++;
      if (cycles > 20) begin
        $display("reset was never released");
        $display("STATUS: FAIL");
        $fatal(1);
      end
    end
    // pc still at its reset value, NOP on the bus
    check_addr("iaddr", '0, iaddr);
    check_bit("d_rw", 1'b0, d_rw);

    // one table entry per cycle, driven 2 ns after the edge
    cycles = 0;
    for (int i = 0; i < n_entries; i++) begin
      idata = t_instr[i];
      #18;
      check_addr("iaddr", t_iaddr[i], iaddr);
      check_bit("d_rw", t_store[i], d_rw);
      if (t_store[i]) begin
        check_addr("daddr", t_daddr[i], daddr);
        check_word("ddata_w", t_wdata[i], ddata_w);
      end
      @(posedge CLK);
      #2;
      cycles++;
      if (cycles > 2 * MAX_ENTRIES) begin
        $display("program table did not complete in time");
        $display("STATUS: FAIL");
        $fatal(1);
      end
    end
    idata = NOP;

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+hw
hw/isa_pkg.sv
hw/core_pkg.sv
hw/ctrl_if.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/imm_gen.sv
hw/execute.sv
hw/fetch_unit.sv
hw/rv_core.sv
dv/clk_gen.sv
dv/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f src.f --top-module tb_core -o vsim \
  || { echo "build failed"; exit 1; }

./obj_dir/vsim > sim.log 2>&1
cat sim.log

grep -q "STATUS: PASS" sim.log && echo "run ok" || { echo "run failed"; exit 1; }
